// ==== files.f ====
+incdir+src
src/predecodePkg.sv
src/bundleFifo.sv
src/predecodeControl.sv
src/boundaryScan.sv
src/classifyStage.sv
src/jumpCollector.sv
src/predecoderTop.sv
test/predecoder_properties.sv
test/predecoderTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = predecoderTb
FILELIST = files.f
OBJDIR   = obj_dir
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== test/predecoderTb.sv ====
/*
  Testbench for predecoderTop with directed bundles, back-pressure and a random stream.
  Expected results come from a reference model of the decode rules.
  The run stops at the first mismatch.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module predecoderTb;
  import predecodePkg::*;

  logic clk;
  logic reset;
  logic bundleValid;
  bundleT bundle;
  logic inCredit;
  logic outValid;
  decodeResultT result;
  logic outCredit;

  decodeResultT expArr [64];   // expected results by send order
  int sent = 0;
  int resultsSeen = 0;
  int returned = 0;
  int inCreditTotal = 0;
  int returnMode = 1;   // 0 hold, 1 at once, 2 random
  int seed = 5;
  int creditSeed = 5;
  int cycles = 0;

  predecoderTop predecoderTop_i (
    .clk(clk), .reset(reset), .bundleValid(bundleValid), .bundle(bundle),
    .inCredit(inCredit), .outValid(outValid), .result(result), .outCredit(outCredit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic instrClassT expClass(input logic [7:0] op);
    instrClassT c;
    c = '0;
    casez (op)
      8'b000??0??, 8'b001000??: c.alu = 1'b1;
      8'b000??1??, 8'b001001??: c.mul = 1'b1;
      8'b010????0: c.load = 1'b1;
      8'b010????1: c.store = 1'b1;
      8'b1010????: begin
        c.jump = 1'b1;   // conditional jump
        c.alu = 1'b1;
      end
      8'hb5: c.jump = 1'b1;
      8'hff: c.sys = 1'b1;
      default: c = '0;
    endcase
    return c;
  endfunction

  function automatic decodeResultT modelResult(input bundleT b);
    decodeResultT r;
    int first;
    int cnt;
    int nj;
    int len;
    r = '0;
    r.error = (b.startOff == 4'd15);
    first = int'(b.startOff);
    cnt = 0;
    for (int e = int'(b.startOff); e < `PD_PARCELS; e++) begin
      if (b.endMarks[e]) begin
        len = e - first + 1;
        if (len > `PD_MAX_IPARCELS || cnt >= `PD_SLOTS) begin
          r.error = 1'b1;
        end else begin
          r.slots[cnt].valid = 1'b1;
          r.slots[cnt].offset = 4'(first);
          r.slots[cnt].len = 3'(len);
          for (int q = 0; q < len; q++) begin
            r.slots[cnt].text[q*`PD_PARCEL_W +: `PD_PARCEL_W] = b.parcels[first + q];
          end
          r.slots[cnt].cls = expClass(b.parcels[first][7:0]);
        end
        cnt++;
        first = e + 1;
      end
    end
    if (r.error) r.slots = '0;
    nj = 0;
    for (int i = 0; i < `PD_SLOTS; i++) begin
      if (r.slots[i].valid && r.slots[i].cls.jump) begin
        if (nj < `PD_JSLOTS) r.jumps[nj] = '{1'b1, 3'(i), r.slots[i].offset, r.slots[i].text};
        else r.jumpOverflow = 1'b1;
        nj++;
      end
    end
    return r;
  endfunction

  task automatic stopRun();
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkSlot(input string name, input instrSlotT got, input instrSlotT want);
    if (got !== want) begin
      $display("Fail %s: got %h, expected %h", name, got, want);
      stopRun();
    end
  endtask

  task automatic checkJump(input string name, input jumpEntryT got, input jumpEntryT want);
    if (got !== want) begin
      $display("Fail %s: got %h, expected %h", name, got, want);
      stopRun();
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("Fail %s: got %h, expected %h", name, got, want);
      stopRun();
    end
  endtask

  // results and credit pulses are sampled away from the active edge
  always @(negedge clk) begin : monitor
    decodeResultT want;
    if (!reset && inCredit) inCreditTotal++;
    if (!reset && outValid) begin
      if (resultsSeen >= sent) begin
        $display("a result came out with no bundle outstanding");
        stopRun();
      end else begin
        want = expArr[resultsSeen];
        for (int i = 0; i < `PD_SLOTS; i++) begin
          checkSlot($sformatf("result.slots[%0d]", i), result.slots[i], want.slots[i]);
        end
        for (int j = 0; j < `PD_JSLOTS; j++) begin
          checkJump($sformatf("result.jumps[%0d]", j), result.jumps[j], want.jumps[j]);
        end
        checkFlag("result.error", result.error, want.error);
        checkFlag("result.jumpOverflow", result.jumpOverflow, want.jumpOverflow);
        resultsSeen++;
      end
    end
  end

  // downstream returns one credit per consumed result
  initial begin
    outCredit = 1'b0;
    forever begin
      @(posedge clk);
      if (returnMode != 0 && resultsSeen > returned &&
          (returnMode == 1 || $random(creditSeed) % 2 == 0)) begin
        outCredit <= 1'b1;
        returned++;
      end else begin
        outCredit <= 1'b0;
      end
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 40 * sent + 200) begin
        $display("timeout after %0d cycles with %0d of %0d results seen",
                 cycles, resultsSeen, sent);
        stopRun();
      end
    end
  end

  function automatic int upCredits();
    return `PD_FIFO_DEPTH - sent + inCreditTotal;
  endfunction

  function automatic bundleT baseBundle(input logic [3:0] off, input logic [15:0] marks);
    bundleT b;
    for (int p = 0; p < `PD_PARCELS; p++) b.parcels[p] = {8'(p), 8'hc0};   // unclassed filler
    b.endMarks = marks;
    b.startOff = off;
    return b;
  endfunction

  task automatic sendBundle(input bundleT b);
    @(posedge clk);
    while (upCredits() == 0) begin
      bundleValid <= 1'b0;
      @(posedge clk);
    end
    bundleValid <= 1'b1;
    bundle <= b;
    expArr[sent] = modelResult(b);
    sent++;
  endtask

  task automatic endSend();
    @(posedge clk);
    bundleValid <= 1'b0;
  endtask

  task automatic waitDrain();
    endSend();
    while (resultsSeen != sent || returned != resultsSeen) @(posedge clk);
  endtask

  task automatic mixedLengths();
    bundleT b;
    b = baseBundle(4'd2, 16'b0001_1000_1001_0101);   // mark at 0 lies below the start
    b.parcels[2] = 16'h1203;
    b.parcels[3] = 16'h3404;
    b.parcels[5] = 16'h0041;
    b.parcels[8] = 16'h0023;
    b.parcels[12] = 16'h00ff;
    sendBundle(b);
    waitDrain();
  endtask

  task automatic jumpLists();
    bundleT b;
    logic [7:0] ops [8];
    ops = '{8'ha1, 8'hb5, 8'h03, 8'ha7, 8'hb5, 8'hb5, 8'h41, 8'h10};
    b = baseBundle(4'd0, 16'h00ff);
    for (int i = 0; i < 8; i++) b.parcels[i][7:0] = ops[i];
    sendBundle(b);
    b = baseBundle(4'd1, 16'h0064);
    b.parcels[1][7:0] = 8'ha3;
    b.parcels[3][7:0] = 8'h42;
    b.parcels[6][7:0] = 8'hb5;
    sendBundle(b);
    waitDrain();
  endtask

  task automatic errorCases();
    sendBundle(baseBundle(4'd0, 16'h0010));   // five parcels long
    sendBundle(baseBundle(4'd0, 16'h01ff));   // nine instructions
    sendBundle(baseBundle(4'd15, 16'h8000));
    waitDrain();
  endtask

  task automatic backPressure();
    bundleT b;
    int baseOut;
    int baseIn;
    returnMode = 0;
    baseOut = resultsSeen;
    baseIn = inCreditTotal;
    for (int n = 0; n < 4; n++) begin
      b = baseBundle(4'(n), 16'haaaa);
      b.parcels[n][7:0] = 8'hb5;
      sendBundle(b);
    end
    endSend();
    repeat (30) @(posedge clk);
    if (resultsSeen - baseOut != `PD_OUT_CREDITS ||
        inCreditTotal - baseIn != `PD_OUT_CREDITS) begin
      $display("without credit returns saw %0d results and %0d inCredit pulses",
               resultsSeen - baseOut, inCreditTotal - baseIn);
      stopRun();
    end
    returnMode = 1;
    waitDrain();
  endtask

  task automatic randomStream();
    bundleT b;
    int p;
    int len;
    returnMode = 2;
    for (int n = 0; n < 30; n++) begin
      for (int i = 0; i < `PD_PARCELS; i++) begin
        b.parcels[i] = 16'($random(seed));
        if ($random(seed) % 4 == 0) b.parcels[i][7:0] = 8'hb5;   // more jumps
      end
      b.startOff = 4'($unsigned($random(seed)) % 8);
      b.endMarks = '0;
      p = int'(b.startOff);
      while (p < `PD_PARCELS) begin
        len = 1 + $unsigned($random(seed)) % 4;
        if ($unsigned($random(seed)) % 16 == 0) len = 5;   // now and then too long
        p += len;
        if (p <= `PD_PARCELS) b.endMarks[p-1] = 1'b1;
      end
      sendBundle(b);
    end
    waitDrain();
  endtask

  initial begin
    reset = 1'b1;
    bundleValid = 1'b0;
    bundle = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    mixedLengths();
    jumpLists();
    errorCases();
    backPressure();
    randomStream();
    if (inCreditTotal == sent) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d bundles sent but %0d inCredit pulses seen", sent, inCreditTotal);
      stopRun();
    end
  end

endmodule

`default_nettype wire

// ==== test/predecoder_properties.sv ====
/*
  Flow-control checks bound into predecoderTop.
  Queue occupancy and output credits are modeled here from the push, pop and credit signals.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module predecoderProperties (
  input logic clk,
  input logic reset,
  input logic push,
  input logic pop,
  input logic outValid,
  input logic outCredit
);
  int occupancy;
  int credits;

  always_ff @(posedge clk) begin
    if (reset) begin
      occupancy <= 0;
      credits <= `PD_OUT_CREDITS;
    end else begin
      occupancy <= occupancy + int'(push) - int'(pop);
      credits <= credits + int'(outCredit) - int'(outValid);
    end
  end

  noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
    push |-> occupancy < `PD_FIFO_DEPTH) else $error("bundle pushed into a full queue");

  creditsInRange: assert property (@(posedge clk) disable iff (reset)
    credits >= 0 && credits <= `PD_OUT_CREDITS) else $error("output credits out of range");

  validNeedsCredit: assert property (@(posedge clk) disable iff (reset)
    outValid |-> credits > 0) else $error("result sent without an output credit");

endmodule

bind predecoderTop predecoderProperties predecoderProperties_i (
  .clk(clk), .reset(reset), .push(bundleValid), .pop(pop),
  .outValid(outValid), .outCredit(outCredit)
);

`default_nettype wire

// ==== src/predecoderTop.sv ====
/*
  Predecoder top level. A popped bundle shows up on result three cycles later.
  Upstream may send only against credits (PD_FIFO_DEPTH at reset, one back per inCredit).
  result is held only for the cycle outValid is high.
*/
`timescale 1ns/1ps
`default_nettype none

module predecoderTop (
  input  logic clk,
  input  logic reset,
  input  logic bundleValid,
  input  predecodePkg::bundleT bundle,
  output logic inCredit,
  output logic outValid,
  output predecodePkg::decodeResultT result,
  input  logic outCredit
);
  import predecodePkg::*;

  bundleT fifoData;
  logic fifoEmpty;
  logic pop;
  logic stage1En;
  logic stage2En;
  logic stage3En;
  slotArrayT scanSlots;
  logic scanError;
  slotArrayT classSlots;
  logic classError;

  bundleFifo bundleFifo_i (
    .clk(clk), .reset(reset),
    .push(bundleValid), .pushData(bundle),
    .pop(pop), .popData(fifoData), .empty(fifoEmpty)
  );

  predecodeControl predecodeControl_i (
    .clk(clk), .reset(reset),
    .empty(fifoEmpty), .outCredit(outCredit), .pop(pop),
    .stage1En(stage1En), .stage2En(stage2En), .stage3En(stage3En),
    .inCredit(inCredit), .outValid(outValid)
  );

  boundaryScan boundaryScan_i (
    .clk(clk), .stage1En(stage1En), .bundle(fifoData),
    .slots(scanSlots), .error(scanError)
  );

  classifyStage classifyStage_i (
    .clk(clk), .stage2En(stage2En), .slotsIn(scanSlots), .errorIn(scanError),
    .slotsOut(classSlots), .errorOut(classError)
  );

  jumpCollector jumpCollector_i (
    .clk(clk), .stage3En(stage3En), .slotsIn(classSlots), .errorIn(classError),
    .result(result)
  );

endmodule

`default_nettype wire

// ==== src/jumpCollector.sv ====
/*
  Stage 3 gathers the first PD_JSLOTS jumps in slot order and registers
  the complete result. Extra jumps only set jumpOverflow.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module jumpCollector (
  input  logic clk,
  input  logic stage3En,
  input  predecodePkg::slotArrayT slotsIn,
  input  logic errorIn,
  output predecodePkg::decodeResultT result
);
  import predecodePkg::*;

  localparam int SW = $clog2(`PD_SLOTS);

  decodeResultT resultNext;

  always_comb begin
    int n;   // jumps seen so far
    n = 0;
    resultNext = '0;   // unused jump entries stay zero
    resultNext.slots = slotsIn;
    resultNext.error = errorIn;
    for (int i = 0; i < `PD_SLOTS; i++) begin
      if (slotsIn[i].valid && slotsIn[i].cls.jump) begin
        if (n < `PD_JSLOTS) begin
          resultNext.jumps[n].valid = 1'b1;
          resultNext.jumps[n].slot = SW'(i);
          resultNext.jumps[n].offset = slotsIn[i].offset;
          resultNext.jumps[n].text = slotsIn[i].text;
        end else begin
          resultNext.jumpOverflow = 1'b1;
        end
        n++;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stage3En) result <= resultNext;
  end

endmodule

`default_nettype wire

// ==== src/classifyStage.sv ====
/*
  Stage 2 fills in the class of every valid slot from the low opcode byte
  of its first parcel. Unknown opcodes get an all-zero class.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module classifyStage (
  input  logic clk,
  input  logic stage2En,
  input  predecodePkg::slotArrayT slotsIn,
  input  logic errorIn,
  output predecodePkg::slotArrayT slotsOut,
  output logic errorOut
);
  import predecodePkg::*;

  slotArrayT slotsNext;

  function automatic instrClassT classify(input logic [7:0] op);
    instrClassT c;
    c = '0;
    if (op[7:5] == 3'b000 || op[7:3] == 5'b00100) begin
      c.alu = ~op[2];
      c.mul = op[2];
    end else if (op[7:5] == 3'b010) begin
      c.load = ~op[0];
      c.store = op[0];
    end else if (op[7:4] == 4'b1010) begin   // conditional jump
      c.jump = 1'b1;
      c.alu = 1'b1;
    end else if (op == 8'd181) begin
      c.jump = 1'b1;
    end else if (op == 8'hff) begin
      c.sys = 1'b1;
    end
    return c;
  endfunction

  always_comb begin
    slotsNext = slotsIn;
    for (int i = 0; i < `PD_SLOTS; i++) begin
      slotsNext[i].cls = slotsIn[i].valid ? classify(slotsIn[i].text[7:0]) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage2En) begin
      slotsOut <= slotsNext;
      errorOut <= errorIn;
    end
  end

endmodule

`default_nettype wire

// ==== src/boundaryScan.sv ====
/*
  Stage 1 splits a bundle into instructions at its end marks.
  The first instruction starts at startOff. Parcels after the last end mark are dropped.
  Error on an overlong instruction, too many instructions or startOff of 15.
  On error all slots are cleared.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module boundaryScan (
  input  logic clk,
  input  logic stage1En,
  input  predecodePkg::bundleT bundle,
  output predecodePkg::slotArrayT slots,
  output logic error
);
  import predecodePkg::*;

  slotArrayT slotsNext;
  logic errorNext;

  always_comb begin
    int n;       // instructions found so far
    int start;   // first parcel of the current instruction
    int len;
    n = 0;
    start = int'(bundle.startOff);
    len = 0;
    slotsNext = '0;
    errorNext = (bundle.startOff == 4'd15);

    for (int p = 0; p < `PD_PARCELS; p++) begin
      // marks below the start offset never match here
      if (p >= start && bundle.endMarks[p]) begin
        len = p - start + 1;
        if (len > `PD_MAX_IPARCELS || n >= `PD_SLOTS) begin
          errorNext = 1'b1;
        end else begin
          slotsNext[n].valid = 1'b1;
          slotsNext[n].offset = 4'(start);
          slotsNext[n].len = 3'(len);
          for (int q = 0; q < `PD_MAX_IPARCELS; q++) begin
            if (q < len) begin
              slotsNext[n].text[q*`PD_PARCEL_W +: `PD_PARCEL_W] =
                bundle.parcels[start + q];
            end
          end
        end
        n++;
        start = p + 1;
      end
    end

    if (errorNext) slotsNext = '0;
  end

  always_ff @(posedge clk) begin
    if (stage1En) begin
      slots <= slotsNext;
      error <= errorNext;
    end
  end

endmodule

`default_nettype wire

// ==== src/predecodeControl.sv ====
/*
  Flow control for the three-stage pipeline.
  A pop happens only when an output credit is free for it, so the stages never stall.
  Downstream must not return more credits than it was given.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module predecodeControl (
  input  logic clk,
  input  logic reset,
  input  logic empty,
  input  logic outCredit,
  output logic pop,
  output logic stage1En,
  output logic stage2En,
  output logic stage3En,
  output logic inCredit,
  output logic outValid
);
  localparam int CW = $clog2(`PD_OUT_CREDITS + 1);

  logic [CW-1:0] credits;    // output credits not yet spent on a result
  logic [CW-1:0] inFlight;   // popped but result not yet out
  logic [2:0] validSr;

  assign pop = !empty && (credits > inFlight);
  assign stage1En = pop;
  assign stage2En = validSr[0];
  assign stage3En = validSr[1];
  assign outValid = validSr[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CW'(`PD_OUT_CREDITS);
      inFlight <= '0;
      validSr <= '0;
      inCredit <= 1'b0;
    end else begin
      validSr <= {validSr[1:0], pop};
      inCredit <= pop;   // one credit back upstream per popped bundle
      case ({outCredit, outValid})
        2'b10: credits <= credits + 1'b1;
        2'b01: credits <= credits - 1'b1;
        default: credits <= credits;   // both or neither cancel out
      endcase
      case ({pop, outValid})
        2'b10: inFlight <= inFlight + 1'b1;
        2'b01: inFlight <= inFlight - 1'b1;
        default: inFlight <= inFlight;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/bundleFifo.sv ====
/*
  Bundle queue with show-ahead output. popData is valid whenever empty is low.
  No full flag. The upstream credit loop keeps pushes within the depth.
*/
`timescale 1ns/1ps
`default_nettype none

`include "predecode_defs.svh"

module bundleFifo (
  input  logic clk,
  input  logic reset,
  input  logic push,
  input  predecodePkg::bundleT pushData,
  input  logic pop,
  output predecodePkg::bundleT popData,
  output logic empty
);
  import predecodePkg::*;

  localparam int AW = $clog2(`PD_FIFO_DEPTH);

  bundleT mem [`PD_FIFO_DEPTH];
  logic [AW-1:0] rdPtr;
  logic [AW-1:0] wrPtr;
  logic [AW:0] count;

  always_ff @(posedge clk) begin
    if (push) mem[wrPtr] <= pushData;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= wrPtr + 1'b1;   // wraps at depth
      if (pop) rdPtr <= rdPtr + 1'b1;
      count <= count + {{AW{1'b0}}, push} - {{AW{1'b0}}, pop};
    end
  end

  assign popData = mem[rdPtr];
  assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== src/predecodePkg.sv ====
/*
  Shared packed types for the predecoder pipeline.
  The text of a slot holds its first parcel in the low bits, and
  parcels past the instruction length are zero.
*/
`default_nettype none

`include "predecode_defs.svh"

package predecodePkg;

  typedef struct packed {
    logic [`PD_PARCELS-1:0][`PD_PARCEL_W-1:0] parcels;
    logic [`PD_PARCELS-1:0] endMarks;   // bit set on the last parcel of an instruction
    logic [3:0] startOff;
  } bundleT;

  typedef struct packed {
    logic jump;
    logic alu;
    logic mul;
    logic load;
    logic store;
    logic sys;
  } instrClassT;

  typedef struct packed {
    logic valid;
    logic [3:0] offset;
    logic [2:0] len;    // in parcels
    logic [`PD_MAX_IPARCELS*`PD_PARCEL_W-1:0] text;
    instrClassT cls;
  } instrSlotT;

  typedef struct packed {
    logic valid;
    logic [$clog2(`PD_SLOTS)-1:0] slot;
    logic [3:0] offset;
    logic [`PD_MAX_IPARCELS*`PD_PARCEL_W-1:0] text;
  } jumpEntryT;

  typedef instrSlotT [`PD_SLOTS-1:0] slotArrayT;

  typedef struct packed {
    slotArrayT slots;
    jumpEntryT [`PD_JSLOTS-1:0] jumps;   // in program order from entry 0
    logic error;
    logic jumpOverflow;
  } decodeResultT;

endpackage

`default_nettype wire

// ==== src/predecode_defs.svh ====
/*
  Sizing constants for the predecoder.
  PD_FIFO_DEPTH is also the upstream credit count and must be a power of two.
  PD_MAX_IPARCELS must not exceed 7, since lengths are held in 3 bits.
*/
`ifndef PREDECODE_DEFS_SVH
`define PREDECODE_DEFS_SVH

// bundle geometry
`define PD_PARCELS 16
`define PD_PARCEL_W 16

// result geometry
`define PD_SLOTS 8
`define PD_JSLOTS 4
`define PD_MAX_IPARCELS 4

// flow control
`define PD_FIFO_DEPTH 4
`define PD_OUT_CREDITS 2

`endif
